//--- source/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// data word and parameter widths
`define DWIDTH   16
`define LWIDTH   8

// address widths of the two memories
`define MEMSIZE  10
`define NETSIZE  8

// fixed 3x3 kernel
`define CONV_KERN 3

// per-channel feature buffer
`define FEASIZE  8
`define ACCWIDTH 40

`endif

//--- source/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

  typedef struct packed {
    logic [`LWIDTH-1:0]  qbits;
    logic [`LWIDTH-1:0]  total_in;
    logic [`LWIDTH-1:0]  total_out;
    logic [`LWIDTH-1:0]  img_height;
    logic [`LWIDTH-1:0]  img_width;
    logic [`LWIDTH-1:0]  conv_pad;
    logic [`LWIDTH-1:0]  conv_strid;
    logic                relu_en;
    logic [`MEMSIZE-1:0] in_offset;
    logic [`MEMSIZE-1:0] out_offset;
    logic [`NETSIZE-1:0] net_offset;
  } layer_params_t;

  // sel 0 for image memory, 1 for network memory
  typedef struct packed {
    logic                we;
    logic                sel;
    logic [`MEMSIZE-1:0] addr;
    logic [`DWIDTH-1:0]  wdata;
  } host_req_t;

  typedef enum logic [1:0] {
    PH_WAIT    = 2'd0,
    PH_NETWORK = 2'd1,
    PH_INPUT   = 2'd2,
    PH_OUTPUT  = 2'd3
  } core_phase_t;

  typedef struct packed {
    logic                valid;
    logic [`MEMSIZE-1:0] addr;
    logic                pad_zero;
    logic [3:0]          tap;
    logic                pix_end;
    logic [`FEASIZE-1:0] pix_index;
  } scan_req_t;

  typedef struct packed {
    logic [`LWIDTH-1:0] fea_height;
    logic [`LWIDTH-1:0] fea_width;
  } fea_sizes_t;

endpackage

//--- source/layer_param_latch.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module layer_param_latch
  import conv_pkg::*;
(
  input  logic          clk,
  input  logic          xrst,
  input  logic          req,
  input  layer_params_t params,
  input  core_phase_t   phase,
  output logic          req_edge,
  output layer_params_t lp,
  output fea_sizes_t    sizes
);

  logic               req_d;
  logic [`LWIDTH-1:0] pad_both;
  logic [`LWIDTH-1:0] ext_height;
  logic [`LWIDTH-1:0] ext_width;
  logic [`LWIDTH-1:0] strid_shift;

  assign req_edge = req && !req_d;

  // padded extent minus kernel
  // only strides 1 and 2 come out exact
  assign pad_both    = params.conv_pad << 1;
  assign ext_height  = params.img_height + pad_both - `LWIDTH'(`CONV_KERN);
  assign ext_width   = params.img_width + pad_both - `LWIDTH'(`CONV_KERN);
  assign strid_shift = params.conv_strid - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst)
      req_d <= 1'b0;
    else
      req_d <= req;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      lp    <= '0;
      sizes <= '0;
    end
    else if (phase == PH_WAIT && req_edge) begin
      lp               <= params;
      sizes.fea_height <= (ext_height >> strid_shift) + 1'b1;
      sizes.fea_width  <= (ext_width >> strid_shift) + 1'b1;
    end
  end

endmodule

//--- source/conv_ctrl_fsm.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_ctrl_fsm
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  logic                req_edge,
  input  layer_params_t       lp,
  input  logic                scan_done,
  input  logic                wb_done,
  output core_phase_t         phase,
  output logic                ack,
  output logic                net_re,
  output logic [`NETSIZE-1:0] net_addr,
  output logic                wreg_we,
  output logic                breg_we,
  output logic [3:0]          wtap,
  output logic                first_input,
  output logic                last_input,
  output logic                scan_start,
  output logic                wb_start,
  output logic [`LWIDTH-1:0]  in_chan,
  output logic [`LWIDTH-1:0]  out_chan
);

  typedef enum logic {W_WEIGHT, W_BIAS} wsub_t;

  wsub_t               wsub;
  logic [3:0]          wcnt;
  logic [`NETSIZE-1:0] net_cnt;
  logic                last_in;
  logic                last_out;
  logic                weight_end;
  logic                net_end;

  assign last_in    = in_chan == lp.total_in - 1'b1;
  assign last_out   = out_chan == lp.total_out - 1'b1;
  assign weight_end = wsub == W_WEIGHT && wcnt == 4'(`CONV_KERN * `CONV_KERN - 1);
  // bias follows the weights of the last input channel only
  assign net_end    = phase == PH_NETWORK && (wsub == W_BIAS || (weight_end && !last_in));

  assign net_re      = phase == PH_NETWORK;
  assign net_addr    = lp.net_offset + net_cnt;
  assign first_input = phase == PH_INPUT && in_chan == '0;
  assign last_input  = phase == PH_INPUT && last_in;

//==========================================================================
// phase sequencing
//==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase    <= PH_WAIT;
      in_chan  <= '0;
      out_chan <= '0;
    end
    else begin
      case (phase)
        PH_WAIT:
          if (req_edge)
            phase <= PH_NETWORK;
        PH_NETWORK:
          if (net_end)
            phase <= PH_INPUT;
        PH_INPUT:
          if (scan_done) begin
            if (last_in) begin
              phase   <= PH_OUTPUT;
              in_chan <= '0;
            end
            else begin
              phase   <= PH_NETWORK;
              in_chan <= in_chan + 1'b1;
            end
          end
        PH_OUTPUT:
          if (wb_done) begin
            if (last_out) begin
              phase    <= PH_WAIT;
              out_chan <= '0;
            end
            else begin
              phase    <= PH_NETWORK;
              out_chan <= out_chan + 1'b1;
            end
          end
      endcase
    end
  end

//==========================================================================
// network reads
//==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wsub <= W_WEIGHT;
      wcnt <= '0;
    end
    else if (phase == PH_NETWORK) begin
      case (wsub)
        W_WEIGHT:
          if (weight_end) begin
            wcnt <= '0;
            if (last_in)
              wsub <= W_BIAS;
          end
          else
            wcnt <= wcnt + 1'b1;
        W_BIAS:
          wsub <= W_WEIGHT;
      endcase
    end
  end

  // runs on through all channels of the layer
  always_ff @(posedge clk) begin
    if (!xrst || phase == PH_WAIT)
      net_cnt <= '0;
    else if (net_re)
      net_cnt <= net_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wreg_we    <= 1'b0;
      breg_we    <= 1'b0;
      wtap       <= '0;
      scan_start <= 1'b0;
      wb_start   <= 1'b0;
      ack        <= 1'b1;
    end
    else begin
      // memory data lands one cycle after the address
      wreg_we    <= net_re && wsub == W_WEIGHT;
      breg_we    <= net_re && wsub == W_BIAS;
      wtap       <= wcnt;
      scan_start <= net_end;
      wb_start   <= phase == PH_INPUT && scan_done && last_in;
      if (phase == PH_WAIT && req_edge)
        ack <= 1'b0;
      else if (phase == PH_OUTPUT && wb_done && last_out)
        ack <= 1'b1;
    end
  end

  // a run needs at least one input and one output channel
  a_run_has_channels : assert property (@(posedge clk) disable iff (!xrst)
    phase == PH_WAIT && req_edge |=> lp.total_in != '0 && lp.total_out != '0);

endmodule

//--- source/window_scan.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module window_scan
  import conv_pkg::*;
(
  input  logic               clk,
  input  logic               xrst,
  input  layer_params_t      lp,
  input  fea_sizes_t         sizes,
  input  logic [`LWIDTH-1:0] in_chan,
  input  logic               scan_start,
  output scan_req_t          sreq,
  output logic               scan_done
);

  localparam int AW = 3 * `LWIDTH + 1;
  localparam logic [AW-1:0] IMG_WORDS = AW'(2 ** `MEMSIZE);

  logic                      busy;
  logic [`LWIDTH-1:0]        oy, ox;
  logic [1:0]                ky, kx;
  logic [`FEASIZE-1:0]       pix;
  logic                      kx_end, win_end, row_end, last_tap;
  logic [`LWIDTH-1:0]        oy_s, ox_s;
  logic signed [`LWIDTH+1:0] iy, ix;
  logic                      pad_zero;
  logic [`LWIDTH-1:0]        row, col;
  logic [AW-1:0]             plane_base, addr_full;

  assign kx_end   = kx == 2'(`CONV_KERN - 1);
  assign win_end  = kx_end && ky == 2'(`CONV_KERN - 1);
  assign row_end  = ox == sizes.fea_width - 1'b1;
  assign last_tap = win_end && row_end && oy == sizes.fea_height - 1'b1;

  // output x,y -> input x,y for this tap
  assign oy_s = oy << (lp.conv_strid - 1'b1);
  assign ox_s = ox << (lp.conv_strid - 1'b1);
  assign iy = $signed({2'b00, oy_s}) + $signed({{`LWIDTH{1'b0}}, ky})
            - $signed({2'b00, lp.conv_pad});
  assign ix = $signed({2'b00, ox_s}) + $signed({{`LWIDTH{1'b0}}, kx})
            - $signed({2'b00, lp.conv_pad});

  assign pad_zero = iy < 0 || ix < 0
                 || iy >= $signed({2'b00, lp.img_height})
                 || ix >= $signed({2'b00, lp.img_width});

  assign row = pad_zero ? '0 : iy[`LWIDTH-1:0];
  assign col = pad_zero ? '0 : ix[`LWIDTH-1:0];

  assign plane_base = AW'(lp.in_offset)
                    + AW'(in_chan) * AW'(lp.img_height) * AW'(lp.img_width);
  assign addr_full  = plane_base + AW'(row) * AW'(lp.img_width) + AW'(col);

  always_comb begin
    sreq.valid     = busy;
    sreq.addr      = addr_full[`MEMSIZE-1:0];
    sreq.pad_zero  = pad_zero;
    sreq.tap       = 4'(ky) * 4'(`CONV_KERN) + 4'(kx);
    sreq.pix_end   = busy && win_end;
    sreq.pix_index = pix;
  end

  // row-major over pixels and then over the 3x3 taps
  always_ff @(posedge clk) begin
    if (!xrst || scan_start) begin
      busy <= xrst && scan_start;
      oy   <= '0;
      ox   <= '0;
      ky   <= '0;
      kx   <= '0;
      pix  <= '0;
    end
    else if (busy) begin
      if (!kx_end)
        kx <= kx + 1'b1;
      else begin
        kx <= '0;
        if (!win_end)
          ky <= ky + 1'b1;
        else begin
          ky  <= '0;
          pix <= pix + 1'b1;
          if (!row_end)
            ox <= ox + 1'b1;
          else begin
            ox <= '0;
            oy <= oy + 1'b1;
            if (last_tap)
              busy <= 1'b0;
          end
        end
      end
    end
  end

  // one cycle late so the last accumulate is in before the fsm moves on
  always_ff @(posedge clk) begin
    if (!xrst)
      scan_done <= 1'b0;
    else
      scan_done <= busy && last_tap;
  end

  a_addr_in_range : assert property (@(posedge clk) disable iff (!xrst)
    sreq.valid && !sreq.pad_zero |-> addr_full < IMG_WORDS);

endmodule

//--- source/conv_mac.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_mac
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  layer_params_t       lp,
  input  scan_req_t           sreq,
  input  logic [`DWIDTH-1:0]  img_rdata,
  input  logic [`DWIDTH-1:0]  net_rdata,
  input  logic                wreg_we,
  input  logic                breg_we,
  input  logic [3:0]          wtap,
  input  logic                first_input,
  input  logic                last_input,
  input  logic [`FEASIZE-1:0] fb_raddr,
  output logic [`DWIDTH-1:0]  fb_rdata
);

  logic signed [`DWIDTH-1:0]   wreg [`CONV_KERN*`CONV_KERN];
  logic signed [`DWIDTH-1:0]   bias;
  logic signed [`ACCWIDTH-1:0] fbuf [2**`FEASIZE];

  logic                        valid_d, pad_d, end_d;
  logic [3:0]                  tap_d;
  logic [`FEASIZE-1:0]         idx_d;
  logic signed [2*`DWIDTH-1:0] mult;
  logic signed [`ACCWIDTH-1:0] acc, product, win_sum, chan_sum;
  logic signed [`ACCWIDTH-1:0] biased, shifted, fb_wdata;
  logic signed [`DWIDTH-1:0]   result;

  assign mult = $signed(img_rdata) * wreg[tap_d];

  always_comb begin
    if (pad_d)
      product = '0;
    else
      product = mult;
    win_sum = acc + product;
    if (first_input)
      chan_sum = win_sum;
    else
      chan_sum = fbuf[idx_d] + win_sum;
    // bias, quantize and relu on the last channel
    biased  = chan_sum + bias;
    shifted = biased >>> lp.qbits;
    if (lp.relu_en && shifted < 0)
      result = '0;
    else
      result = shifted[`DWIDTH-1:0];
    if (last_input)
      fb_wdata = result;
    else
      fb_wdata = chan_sum;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_d <= 1'b0;
      acc     <= '0;
    end
    else begin
      valid_d <= sreq.valid;
      if (valid_d)
        acc <= end_d ? '0 : win_sum;
    end
  end

  // tap info lines up with the image read data
  always_ff @(posedge clk) begin
    pad_d <= sreq.pad_zero;
    tap_d <= sreq.tap;
    end_d <= sreq.pix_end;
    idx_d <= sreq.pix_index;
    if (wreg_we)
      wreg[wtap] <= net_rdata;
    if (breg_we)
      bias <= net_rdata;
    if (valid_d && end_d)
      fbuf[idx_d] <= fb_wdata;
    fb_rdata <= fbuf[fb_raddr][`DWIDTH-1:0];
  end

endmodule

//--- source/feature_writeback.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module feature_writeback
  import conv_pkg::*;
(
  input  logic                clk,
  input  logic                xrst,
  input  layer_params_t       lp,
  input  fea_sizes_t          sizes,
  input  logic [`LWIDTH-1:0]  out_chan,
  input  logic                wb_start,
  input  logic [`DWIDTH-1:0]  fb_rdata,
  output logic [`FEASIZE-1:0] fb_raddr,
  output logic                wb_we,
  output logic [`MEMSIZE-1:0] wb_addr,
  output logic [`DWIDTH-1:0]  wb_data,
  output logic                wb_done
);

  logic                  busy;
  logic [`FEASIZE-1:0]   cnt;
  logic [2*`LWIDTH-1:0]  area;
  logic                  last;
  logic [`MEMSIZE-1:0]   dest_base;

  assign area      = sizes.fea_height * sizes.fea_width;
  assign last      = cnt == `FEASIZE'(area - 1'b1);
  // planes are packed back to back from out_offset
  assign dest_base = lp.out_offset + `MEMSIZE'(out_chan * area);

  assign fb_raddr = cnt;
  assign wb_data  = fb_rdata;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (wb_start) begin
      busy <= 1'b1;
      cnt  <= '0;
    end
    else if (busy) begin
      cnt <= cnt + 1'b1;
      if (last)
        busy <= 1'b0;
    end
  end

  // the buffer read takes a cycle and the write follows it
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wb_we   <= 1'b0;
      wb_done <= 1'b0;
    end
    else begin
      wb_we   <= busy;
      wb_done <= busy && last;
    end
  end

  always_ff @(posedge clk)
    wb_addr <= dest_base + `MEMSIZE'(cnt);

endmodule

//--- source/layer_memories.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module layer_memories
  import conv_pkg::*;
(
  input  logic                clk,
  input  host_req_t           host_req,
  input  core_phase_t         phase,
  input  scan_req_t           sreq,
  input  logic                net_re,
  input  logic [`NETSIZE-1:0] net_addr,
  input  logic                wb_we,
  input  logic [`MEMSIZE-1:0] wb_addr,
  input  logic [`DWIDTH-1:0]  wb_data,
  output logic [`DWIDTH-1:0]  host_rdata,
  output logic [`DWIDTH-1:0]  img_rdata,
  output logic [`DWIDTH-1:0]  net_rdata
);

  logic [`DWIDTH-1:0]  img_mem [2**`MEMSIZE];
  logic [`DWIDTH-1:0]  net_mem [2**`NETSIZE];

  logic                img_we, net_we;
  logic [`MEMSIZE-1:0] img_addr;
  logic [`NETSIZE-1:0] net_port_addr;
  logic [`DWIDTH-1:0]  img_wdata;
  logic                sel_d;

  // phase decides who owns each array
  always_comb begin
    img_we    = 1'b0;
    img_addr  = host_req.addr;
    img_wdata = host_req.wdata;
    case (phase)
      PH_WAIT:
        img_we = host_req.we && !host_req.sel;
      PH_INPUT:
        img_addr = sreq.addr;
      PH_OUTPUT: begin
        img_we    = wb_we;
        img_addr  = wb_addr;
        img_wdata = wb_data;
      end
      default: ;
    endcase
  end

  assign net_we        = phase == PH_WAIT && host_req.we && host_req.sel;
  assign net_port_addr = net_re ? net_addr : host_req.addr[`NETSIZE-1:0];

  always_ff @(posedge clk) begin
    if (img_we)
      img_mem[img_addr] <= img_wdata;
    img_rdata <= img_mem[img_addr];
  end

  always_ff @(posedge clk) begin
    if (net_we)
      net_mem[net_port_addr] <= host_req.wdata;
    net_rdata <= net_mem[net_port_addr];
    sel_d     <= host_req.sel;
  end

  assign host_rdata = sel_d ? net_rdata : img_rdata;

  // ack is high exactly while the phase is PH_WAIT
  a_host_write_idle : assert property (@(posedge clk)
    host_req.we |-> phase == PH_WAIT);

endmodule

//--- source/conv_layer_top.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_layer_top
  import conv_pkg::*;
(
  input  logic               clk,
  input  logic               xrst,
  input  logic               req,
  input  layer_params_t      params,
  input  host_req_t          host_req,
  output logic               ack,
  output logic [`DWIDTH-1:0] host_rdata,
  output core_phase_t        phase
);

  logic                req_edge;
  layer_params_t       lp;
  fea_sizes_t          sizes;
  logic                net_re;
  logic [`NETSIZE-1:0] net_addr;
  logic                wreg_we, breg_we;
  logic [3:0]          wtap;
  logic                first_input, last_input;
  logic                scan_start, scan_done;
  logic                wb_start, wb_done;
  logic [`LWIDTH-1:0]  in_chan, out_chan;
  scan_req_t           sreq;
  logic [`DWIDTH-1:0]  img_rdata, net_rdata, fb_rdata;
  logic [`FEASIZE-1:0] fb_raddr;
  logic                wb_we;
  logic [`MEMSIZE-1:0] wb_addr;
  logic [`DWIDTH-1:0]  wb_data;

  layer_param_latch u_latch (
    .clk, .xrst, .req, .params, .phase, .req_edge, .lp, .sizes
  );

  conv_ctrl_fsm u_fsm (
    .clk, .xrst, .req_edge, .lp, .scan_done, .wb_done, .phase, .ack,
    .net_re, .net_addr, .wreg_we, .breg_we, .wtap, .first_input, .last_input,
    .scan_start, .wb_start, .in_chan, .out_chan
  );

  window_scan u_scan (
    .clk, .xrst, .lp, .sizes, .in_chan, .scan_start, .sreq, .scan_done
  );

  conv_mac u_mac (
    .clk, .xrst, .lp, .sreq, .img_rdata, .net_rdata, .wreg_we, .breg_we,
    .wtap, .first_input, .last_input, .fb_raddr, .fb_rdata
  );

  feature_writeback u_wb (
    .clk, .xrst, .lp, .sizes, .out_chan, .wb_start, .fb_rdata,
    .fb_raddr, .wb_we, .wb_addr, .wb_data, .wb_done
  );

  layer_memories u_mem (
    .clk, .host_req, .phase, .sreq, .net_re, .net_addr, .wb_we, .wb_addr,
    .wb_data, .host_rdata, .img_rdata, .net_rdata
  );

endmodule

//--- verif/conv_layer_tb.sv
`timescale 1ns/10ps
`include "conv_settings.svh"

module conv_layer_tb
  import conv_pkg::*;
();

  localparam string STIM_FILE = "verif/conv_layer_stim.txt";

  logic               clk;
  logic               xrst;
  logic               req;
  layer_params_t      params;
  host_req_t          host_req;
  logic               ack;
  logic [`DWIDTH-1:0] host_rdata;
  core_phase_t        phase;

  int errors;
  int checks;
  int limit_cycles;
  int fd;
  int n_req;
  int n_words;

  conv_layer_top conv_layer_top_inst (
    .clk, .xrst, .req, .params, .host_req, .ack, .host_rdata, .phase
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // limit known once the stimulus file has been counted
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: ack did not return within %0d cycles, run stopped", limit_cycles);
    $display("Some tests failed");
    $finish;
  end

//============================================================================
// host side tasks
//============================================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_word(input bit sel, input int addr, input logic [`DWIDTH-1:0] data);
    host_req.we    = 1'b1;
    host_req.sel   = sel;
    host_req.addr  = `MEMSIZE'(addr);
    host_req.wdata = data;
    next_cycle();
    host_req.we    = 1'b0;
  endtask

  // read data is registered and arrives one cycle later
  task automatic check_image_word(input int addr, input logic [`DWIDTH-1:0] expected);
    host_req.we   = 1'b0;
    host_req.sel  = 1'b0;
    host_req.addr = `MEMSIZE'(addr);
    next_cycle();
    checks++;
    if (host_rdata !== expected) begin
      errors++;
      $display("error at %0t: image addr %0d expected %h got %h",
               $time, addr, expected, host_rdata);
    end
  endtask

  task automatic run_layer(input layer_params_t p);
    params = p;
    req    = 1'b1;
    next_cycle();
    checks++;
    if (ack !== 1'b0) begin
      errors++;
      $display("error at %0t: ack still high one cycle after the request", $time);
    end
    while (ack !== 1'b1)
      next_cycle();
    req = 1'b0;
    next_cycle();
  endtask

//============================================================================
// stimulus file counted first and then run
//============================================================================

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1)
      c = $fgetc(fd);
  endtask

  task automatic scan_stim(input int fd, input bit dry, output int reqs, output int words);
    logic [7:0]         kind;
    logic [`DWIDTH-1:0] value;
    layer_params_t      p;
    int                 pv [11];
    int                 n, sel, addr, count, i;
    bit                 done;
    reqs  = 0;
    words = 0;
    done  = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1)
        done = 1'b1;
      else if (kind == "#")
        skip_line(fd);
      else if (kind == "W" || kind == "R") begin
        if (kind == "W")
          n = $fscanf(fd, "%d %d %d", sel, addr, count);
        else
          n = $fscanf(fd, "%d %d", addr, count);
        for (i = 0; i < count; i++) begin
          n = $fscanf(fd, "%h", value);
          words++;
          if (!dry && kind == "W")
            write_word(sel != 0, addr + i, value);
          else if (!dry)
            check_image_word(addr + i, value);
        end
      end
      else if (kind == "P") begin
        for (i = 0; i < 11; i++)
          n = $fscanf(fd, "%d", pv[i]);
        reqs++;
        if (!dry) begin
          p.qbits      = `LWIDTH'(pv[0]);
          p.total_in   = `LWIDTH'(pv[1]);
          p.total_out  = `LWIDTH'(pv[2]);
          p.img_height = `LWIDTH'(pv[3]);
          p.img_width  = `LWIDTH'(pv[4]);
          p.conv_pad   = `LWIDTH'(pv[5]);
          p.conv_strid = `LWIDTH'(pv[6]);
          p.relu_en    = pv[7] != 0;
          p.in_offset  = `MEMSIZE'(pv[8]);
          p.out_offset = `MEMSIZE'(pv[9]);
          p.net_offset = `NETSIZE'(pv[10]);
          run_layer(p);
        end
      end
      else begin
        if (dry) begin
          errors++;
          $display("stimulus file has a line of unknown type %c", kind);
        end
        done = 1'b1;
      end
    end
  endtask

//============================================================================
// main sequence
//============================================================================

  initial begin
    xrst         = 1'b0;
    req          = 1'b0;
    params       = '0;
    host_req     = '0;
    errors       = 0;
    checks       = 0;
    limit_cycles = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file %s", STIM_FILE);
    end
    else begin
      scan_stim(fd, 1'b1, n_req, n_words);
      $fclose(fd);
      limit_cycles = 4000 * n_req + 2 * n_words + 100;
      repeat (10) @(posedge clk);
      #1;
      xrst = 1'b1;
      next_cycle();
      checks++;
      if (ack !== 1'b1 || phase !== PH_WAIT) begin
        errors++;
        $display("error at %0t: after reset ack %b phase %0d, expected ack 1 and PH_WAIT",
                 $time, ack, phase);
      end
      fd = $fopen(STIM_FILE, "r");
      scan_stim(fd, 1'b0, n_req, n_words);
      $fclose(fd);
    end
    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- verif/conv_layer_stim.txt
# W sel addr count data... : host write, sel 0 image 1 network, addr decimal, data hex
# P qbits in out height width pad stride relu in_off out_off net_off : one layer, decimal
# R addr count expected... : image read and compare, addr decimal, data hex
# input planes, 4x4 ramp, 4x4 signed plane, 5x5 ramp
W 0 0 16 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F 0010
W 0 16 16 0000 0001 0002 0003 FFFF 0000 0001 0002 FFFE FFFF 0000 0001 FFFD FFFE FFFF 0000
W 0 200 15 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F
W 0 215 10 0010 0011 0012 0013 0014 0015 0016 0017 0018 0019
# guard words just past each output area
W 0 104 1 5A5A
W 0 136 1 5A5A
W 0 144 1 5A5A
W 0 308 1 5A5A
# weights then bias per output channel
W 1 0 10 0002 0000 FFFF 0001 0001 0000 0000 FFFF 0003 FFD3
W 1 16 10 0001 0001 0001 0001 0001 0001 0001 0001 0001 0000
W 1 32 9 0001 0001 0001 0001 0001 0001 0001 0001 0001
W 1 41 10 0000 0000 0000 0000 0002 0000 0000 0000 0000 FFC4
W 1 51 9 FFFF 0000 0000 0000 0000 0000 0000 0000 0000
W 1 60 10 0000 0000 0000 0000 0000 0000 0000 0000 0004 0008
# host readback while idle
R 0 16 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F 0010
R 16 16 0000 0001 0002 0003 FFFF 0000 0001 0002 FFFE FFFF 0000 0001 FFFD FFFE FFFF 0000
# stride 1 pad 0, bias -45 and shift 1
P 1 1 1 4 4 0 1 0 0 100 0
R 100 4 FFFA FFFC 0004 0006
R 104 1 5A5A
# pad 1, all-ones kernel
P 0 1 1 4 4 1 1 0 0 120 16
R 120 8 000E 0018 001E 0016 0021 0036 003F 002D
R 128 8 0039 005A 0063 0045 002E 0048 004E 0036
R 136 1 5A5A
# stride 2 on 5x5 with new offsets
P 1 1 1 5 5 0 2 0 200 140 0
R 140 4 FFFD 0002 0016 001B
R 144 1 5A5A
# two in, two out, relu
P 2 2 2 4 4 0 1 1 0 300 32
R 300 8 0000 0001 0007 0009 0001 0002 0000 0000
R 308 1 5A5A
# earlier results left in place
R 100 4 FFFA FFFC 0004 0006
R 120 4 000E 0018 001E 0016
R 0 4 0001 0002 0003 0004

//--- project.f
+incdir+source
source/conv_pkg.sv
source/layer_param_latch.sv
source/conv_ctrl_fsm.sv
source/window_scan.sv
source/conv_mac.sv
source/feature_writeback.sv
source/layer_memories.sv
source/conv_layer_top.sv
verif/conv_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_layer_tb -f project.f -o conv_layer_sim

./obj_dir/conv_layer_sim > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
